/* common/sys_periph_consts.svh */
`ifndef SYS_PERIPH_CONSTS_SVH
`define SYS_PERIPH_CONSTS_SVH

//--------------------------------------------------------------------------
// Address map (word addresses)
//--------------------------------------------------------------------------
`define SFR_BASE_ADDR   14'h000
`define SFR_DEC_WD      4         // Byte address bits decoded locally

`define WDT_BASE_ADDR   14'h090   // Byte 0x0120
`define WDT_CTL_OFFSET  14'h000   // WDTCTL word

//--------------------------------------------------------------------------
// Watchdog keys
//--------------------------------------------------------------------------
`define WDT_PASSWORD    8'h5A     // Write key in high byte
`define WDT_READ_KEY    8'h69     // Returned on reads

//--------------------------------------------------------------------------
// Build identity
//--------------------------------------------------------------------------
`define CPU_VERSION     3'd3
`define USER_VERSION    5'd0

// Memory sizes in bytes
`define PER_SIZE        512
`define DMEM_SIZE       1024
`define PMEM_SIZE       4096

// Size fields are scaled down before packing
// PER in 512 byte units, DMEM in 128, PMEM in 1k
// Keep sizes multiples of those units

`endif

/* common/sys_periph_pkg.sv */
package sys_periph_pkg;

  // One peripheral bus access, completes in its own cycle
  typedef struct packed {
    logic [13:0] addr;  // Word address
    logic [15:0] din;   // Write data
    logic        en;    // Access strobe
    logic [1:0]  we;    // Byte write enables (zero for a read)
  } per_req_t;

  // Watchdog state seen by the SFR block
  typedef struct packed {
    logic wdtifg;    // Watchdog interrupt flag
    logic wdtnmies;  // High selects falling NMI edge
  } wdt_sfr_t;

  // SFR block strobes towards the watchdog
  typedef struct packed {
    logic wdtie;          // Interrupt enable level
    logic wdtifg_sw_set;  // IFG1 write with bit 0 high
    logic wdtifg_sw_clr;  // IFG1 write with bit 0 low
  } sfr_wdt_t;

  // WDTCTL interval select field
  typedef enum logic [1:0] {
    intvl_32k = 2'd0,  // 32768 mclk
    intvl_8k  = 2'd1,  // 8192 mclk
    intvl_512 = 2'd2,
    intvl_64  = 2'd3
  } wdt_intvl_e;

  // SFR word offsets
  typedef enum logic [2:0] {
    reg_ie1       = 3'd0,
    reg_ifg1      = 3'd1,
    reg_cpu_id_lo = 3'd2,
    reg_cpu_id_hi = 3'd3,
    reg_cpu_nr    = 3'd4
  } sfr_reg_e;

endpackage

/* sfr/sfr_regs.sv */
`timescale 1ns/1ps

`include "sys_periph_consts.svh"

module sfr_regs
  import sys_periph_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  per_req_t    per_req,       // Shared bus request
  output logic [15:0] per_dout,      // Zero unless read here
  input  logic [7:0]  cpu_nr_inst,   // This instance number
  input  logic [7:0]  cpu_nr_total,  // Instance count minus one
  input  logic        nmi,           // Raw NMI pin
  input  logic        nmi_acc,       // NMI taken by CPU
  input  wdt_sfr_t    wdt_stat,      // From watchdog
  output sfr_wdt_t    wdt_ctl,       // To watchdog
  output logic [31:0] cpu_id,
  output logic        nmi_pnd
);

  localparam logic [13:0] BASE_ADDR = `SFR_BASE_ADDR;
  localparam int          OFF_WD    = `SFR_DEC_WD - 1;  // Word offset bits
  localparam int          NUM_REGS  = 5;

  // Identity fields
  localparam logic [2:0] CPU_VERSION  = `CPU_VERSION;
  localparam logic       CPU_ASIC     = 1'b0;                  // No ASIC clocking
  localparam logic [4:0] USER_VERSION = `USER_VERSION;
  localparam logic [6:0] PER_SPACE    = 7'(`PER_SIZE >> 9);   // 512 byte units
  localparam logic       MPY_INFO     = 1'b0;                  // No multiplier
  localparam logic [8:0] DMEM_SIZE    = 9'(`DMEM_SIZE >> 7);  // 128 byte units
  localparam logic [5:0] PMEM_SIZE    = 6'(`PMEM_SIZE >> 10); // 1k units

  logic                reg_sel;
  sfr_reg_e            reg_off;
  logic [NUM_REGS-1:0] reg_dec;
  logic                reg_lo_wr;
  logic                reg_rd;
  logic                ie1_wr;
  logic                ifg1_wr;
  logic                nmie;
  logic                wdtie;
  logic                nmiifg;
  logic [7:0]          ie1;
  logic [7:0]          ifg1;
  logic [15:0]         cpu_nr;
  logic                nmi_pol;
  logic [1:0]          nmi_sync;
  logic                nmi_dly;
  logic                nmi_edge;

  //--------------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------------

  // Block hit on upper word address bits
  assign reg_sel = per_req.en & (per_req.addr[13:OFF_WD] == BASE_ADDR[13:OFF_WD]);
  assign reg_off = sfr_reg_e'(per_req.addr[OFF_WD-1:0]);

  // One-hot register select, holes decode to nothing
  always_comb begin
    reg_dec = '0;
    case (reg_off)
      reg_ie1:       reg_dec[reg_ie1]       = 1'b1;
      reg_ifg1:      reg_dec[reg_ifg1]      = 1'b1;
      reg_cpu_id_lo: reg_dec[reg_cpu_id_lo] = 1'b1;
      reg_cpu_id_hi: reg_dec[reg_cpu_id_hi] = 1'b1;
      reg_cpu_nr:    reg_dec[reg_cpu_nr]    = 1'b1;
      default:       reg_dec                = '0;
    endcase
  end

  // Writable bits all sit in the low byte
  assign reg_lo_wr = reg_sel & per_req.we[0];
  assign reg_rd    = reg_sel & ~|per_req.we;

  assign ie1_wr  = reg_lo_wr & reg_dec[reg_ie1];
  assign ifg1_wr = reg_lo_wr & reg_dec[reg_ifg1];

  //--------------------------------------------------------------------------
  // IE1
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      nmie <= 1'b0;
    end else if (nmi_acc) begin
      nmie <= 1'b0;                 // Accept masks further NMIs
    end else if (ie1_wr) begin
      nmie <= per_req.din[4];
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtie <= 1'b0;
    end else if (ie1_wr) begin
      wdtie <= per_req.din[0];
    end
  end

  assign ie1 = {3'b000, nmie, 3'b000, wdtie};

  //--------------------------------------------------------------------------
  // IFG1
  //--------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      nmiifg <= 1'b0;
    end else if (nmi_edge) begin
      nmiifg <= 1'b1;               // Edge wins over software
    end else if (ifg1_wr) begin
      nmiifg <= per_req.din[4];
    end
  end

  // Watchdog flag lives in the timer, only strobes go out
  assign wdt_ctl = '{
    wdtie:         wdtie,
    wdtifg_sw_set: ifg1_wr & per_req.din[0],
    wdtifg_sw_clr: ifg1_wr & ~per_req.din[0]
  };

  assign ifg1 = {3'b000, nmiifg, 3'b000, wdt_stat.wdtifg};

  // Identity layout
  //   LO  [15:9] per space  [8:4] user ver  [3] asic  [2:0] cpu ver
  //   HI  [15:10] pmem      [9:1] dmem      [0] mpy
  assign cpu_id = {PMEM_SIZE, DMEM_SIZE, MPY_INFO,
                   PER_SPACE, USER_VERSION, CPU_ASIC, CPU_VERSION};

  assign cpu_nr = {cpu_nr_total, cpu_nr_inst};  // Total in high byte

  //--------------------------------------------------------------------------
  // NMI capture
  //--------------------------------------------------------------------------

  // Polarity folded in so a rising edge is always the active one
  assign nmi_pol = nmi ^ wdt_stat.wdtnmies;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      nmi_sync <= 2'b00;
      nmi_dly  <= 1'b0;
    end else begin
      nmi_sync <= {nmi_sync[0], nmi_pol};  // Two flop sync
      nmi_dly  <= nmi_sync[1];
    end
  end

  assign nmi_edge = nmi_sync[1] & ~nmi_dly;
  assign nmi_pnd  = nmiifg & nmie;

  //--------------------------------------------------------------------------
  // Read data
  //--------------------------------------------------------------------------
  assign per_dout = ({8'h00, ie1}   & {16{reg_rd & reg_dec[reg_ie1]}})       |
                    ({8'h00, ifg1}  & {16{reg_rd & reg_dec[reg_ifg1]}})      |
                    (cpu_id[15:0]   & {16{reg_rd & reg_dec[reg_cpu_id_lo]}}) |
                    (cpu_id[31:16]  & {16{reg_rd & reg_dec[reg_cpu_id_hi]}}) |
                    (cpu_nr         & {16{reg_rd & reg_dec[reg_cpu_nr]}});

endmodule

/* watchdog/watchdog_timer.sv */
`timescale 1ns/1ps

`include "sys_periph_consts.svh"

module watchdog_timer
  import sys_periph_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  per_req_t    per_req,      // Shared bus request
  output logic [15:0] per_dout,     // Zero unless read here
  input  sfr_wdt_t    sfr_ctl,      // Enable and flag strobes
  output wdt_sfr_t    wdt_stat,     // Flag and NMI edge select
  input  logic        wdt_irq_acc,  // Interval IRQ taken
  output logic        wdt_irq,
  output logic        wdt_reset     // One cycle reset request
);

  localparam logic [13:0] CTL_ADDR = `WDT_BASE_ADDR + `WDT_CTL_OFFSET;

  logic        reg_sel;
  logic        ctl_wr;
  logic        ctl_rd;
  logic        pw_ok;
  logic        pw_err;
  logic        cfg_wr;
  logic        cntcl_wr;
  logic        wdthold;
  logic        wdtnmies;
  logic        wdttmsel;
  wdt_intvl_e  wdtis;
  logic [7:0]  wdtctl;
  logic [15:0] wdtcnt;
  logic [15:0] cnt_limit;
  logic        cnt_expire;
  logic        wdtifg;
  logic        ifg_set;
  logic        ifg_clr;

  //--------------------------------------------------------------------------
  // WDTCTL access and password
  //--------------------------------------------------------------------------
  assign reg_sel = per_req.en & (per_req.addr == CTL_ADDR);
  assign ctl_wr  = reg_sel & |per_req.we;
  assign ctl_rd  = reg_sel & ~|per_req.we;

  // Key checked on any write, whatever the byte enables
  assign pw_ok  = (per_req.din[15:8] == `WDT_PASSWORD);
  assign pw_err = ctl_wr & ~pw_ok;

  // Control bits only change with good key and low byte enabled
  assign cfg_wr   = ctl_wr & pw_ok & per_req.we[0];
  assign cntcl_wr = cfg_wr & per_req.din[3];   // Strobe only, not stored

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdthold  <= 1'b0;
      wdtnmies <= 1'b0;
      wdttmsel <= 1'b0;          // Watchdog mode
      wdtis    <= intvl_32k;
    end else if (cfg_wr) begin
      wdthold  <= per_req.din[7];
      wdtnmies <= per_req.din[6];
      wdttmsel <= per_req.din[4];
      wdtis    <= wdt_intvl_e'(per_req.din[1:0]);
    end
  end

  // Bit 5 and 2 unimplemented, CNTCL reads back as 0
  assign wdtctl = {wdthold, wdtnmies, 1'b0, wdttmsel, 1'b0, 1'b0, wdtis};

  //--------------------------------------------------------------------------
  // Interval counter
  //--------------------------------------------------------------------------

  // Terminal count per interval select
  always_comb begin
    case (wdtis)
      intvl_32k: cnt_limit = 16'h7fff;
      intvl_8k:  cnt_limit = 16'h1fff;
      intvl_512: cnt_limit = 16'h01ff;
      default:   cnt_limit = 16'h003f;   // intvl_64
    endcase
  end

  // A clear on the terminal cycle cancels the expiry
  assign cnt_expire = ~wdthold & (wdtcnt == cnt_limit) & ~cntcl_wr;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtcnt <= 16'h0000;
    end else if (cntcl_wr | cnt_expire) begin
      wdtcnt <= 16'h0000;                // Wrap or software clear
    end else if (~wdthold) begin
      wdtcnt <= wdtcnt + 16'd1;
    end
  end

  //--------------------------------------------------------------------------
  // Flag, interrupt and reset request
  //--------------------------------------------------------------------------
  assign ifg_set = cnt_expire | sfr_ctl.wdtifg_sw_set;
  assign ifg_clr = sfr_ctl.wdtifg_sw_clr | wdt_irq_acc;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtifg <= 1'b0;
    end else if (ifg_set) begin
      wdtifg <= 1'b1;                    // Set has priority
    end else if (ifg_clr) begin
      wdtifg <= 1'b0;
    end
  end

  // Interrupt only in interval mode
  assign wdt_irq = wdtifg & sfr_ctl.wdtie & wdttmsel;

  // Bad key or watchdog mode expiry, one cycle after the edge
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdt_reset <= 1'b0;
    end else begin
      wdt_reset <= pw_err | (cnt_expire & ~wdttmsel);
    end
  end

  assign wdt_stat = '{
    wdtifg:   wdtifg,
    wdtnmies: wdtnmies
  };

  // Read returns key byte over control byte
  assign per_dout = {`WDT_READ_KEY, wdtctl} & {16{ctl_rd}};

endmodule

/* verilog/sys_periph_top.sv */
`timescale 1ns/1ps

module sys_periph_top
  import sys_periph_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  per_req_t    per_req,       // Bus request to both blocks
  output logic [15:0] per_dout,      // Merged read data
  input  logic [7:0]  cpu_nr_inst,
  input  logic [7:0]  cpu_nr_total,
  input  logic        nmi,           // Asynchronous NMI pin
  input  logic        nmi_acc,
  input  logic        wdt_irq_acc,
  output logic [31:0] cpu_id,
  output logic        nmi_pnd,
  output logic        wdt_irq,
  output logic        wdt_reset
);

  sfr_wdt_t    sfr_to_wdt;    // Enable level and flag strobes
  wdt_sfr_t    wdt_to_sfr;    // Flag and edge select
  logic [15:0] sfr_dout;
  logic [15:0] wdt_dout;

  // Special function registers
  sfr_regs u_sfr (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .per_req      (per_req),
    .per_dout     (sfr_dout),
    .cpu_nr_inst  (cpu_nr_inst),
    .cpu_nr_total (cpu_nr_total),
    .nmi          (nmi),
    .nmi_acc      (nmi_acc),
    .wdt_stat     (wdt_to_sfr),
    .wdt_ctl      (sfr_to_wdt),
    .cpu_id       (cpu_id),
    .nmi_pnd      (nmi_pnd)
  );

  // Watchdog timer with its WDTCTL
  watchdog_timer u_wdt (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_req     (per_req),
    .per_dout    (wdt_dout),
    .sfr_ctl     (sfr_to_wdt),
    .wdt_stat    (wdt_to_sfr),
    .wdt_irq_acc (wdt_irq_acc),
    .wdt_irq     (wdt_irq),
    .wdt_reset   (wdt_reset)
  );

  // Unselected block drives zero so OR is enough
  assign per_dout = sfr_dout | wdt_dout;

endmodule

/* tb/sys_periph_model.svh */
`ifndef SYS_PERIPH_MODEL_SVH
`define SYS_PERIPH_MODEL_SVH

//--------------------------------------------------------------------------
// Reference state, stepped once per rising mclk
//--------------------------------------------------------------------------
logic        m_nmie;
logic        m_wdtie;
logic        m_nmiifg;
logic [2:0]  m_nmi_pipe;     // Sync, sync, delay
logic [7:0]  m_wdtctl;       // Stored control bits, CNTCL never kept
logic [15:0] m_cnt;
logic        m_wdtifg;
logic        m_wdt_reset;

// Interval length in mclk cycles
function automatic int interval_len(input wdt_intvl_e sel);
  case (sel)
    intvl_32k: return 32768;
    intvl_8k:  return 8192;
    intvl_512: return 512;
    default:   return 64;
  endcase
endfunction

// Identity word from the build constants
function automatic logic [31:0] expected_cpu_id();
  return {6'(`PMEM_SIZE / 1024), 9'(`DMEM_SIZE / 128), 1'b0,
          7'(`PER_SIZE / 512), `USER_VERSION, 1'b0, `CPU_VERSION};
endfunction

task automatic clear_model();
  m_nmie      = 1'b0;
  m_wdtie     = 1'b0;
  m_nmiifg    = 1'b0;
  m_nmi_pipe  = 3'b000;
  m_wdtctl    = 8'h00;   // Watchdog mode, 32k interval
  m_cnt       = 16'h0000;
  m_wdtifg    = 1'b0;
  m_wdt_reset = 1'b0;
endtask

task automatic advance_model(input per_req_t req, input logic pin, input logic nacc,
                             input logic wacc);
  logic sfr_hit;
  logic ie1_wr;
  logic ifg1_wr;
  logic wdt_wr;
  logic key_ok;
  logic cfg_wr;
  logic cntcl;
  logic expire;
  logic nmi_rise;
  sfr_hit  = req.en && ((req.addr >> 3) == (`SFR_BASE_ADDR >> 3));  // 8 word window
  ie1_wr   = sfr_hit && req.we[0] && (req.addr[2:0] == 3'(reg_ie1));
  ifg1_wr  = sfr_hit && req.we[0] && (req.addr[2:0] == 3'(reg_ifg1));
  wdt_wr   = req.en && (req.addr == `WDT_BASE_ADDR) && (req.we != 2'b00);
  key_ok   = (req.din[15:8] == `WDT_PASSWORD);
  cfg_wr   = wdt_wr && key_ok && req.we[0];
  cntcl    = cfg_wr && req.din[3];
  expire   = !m_wdtctl[7] && !cntcl &&
             (m_cnt == interval_len(wdt_intvl_e'(m_wdtctl[1:0])) - 1);
  nmi_rise = m_nmi_pipe[1] && !m_nmi_pipe[2];

  // Everything below reads pre-edge state
  m_wdt_reset = (wdt_wr && !key_ok) || (expire && !m_wdtctl[4]);
  if (expire || (ifg1_wr && req.din[0]))
    m_wdtifg = 1'b1;                       // Set beats clear
  else if ((ifg1_wr && !req.din[0]) || wacc)
    m_wdtifg = 1'b0;
  if (cntcl || expire)
    m_cnt = 16'h0000;
  else if (!m_wdtctl[7])
    m_cnt = m_cnt + 16'd1;
  m_nmi_pipe = {m_nmi_pipe[1:0], pin ^ m_wdtctl[6]};  // Old edge select
  if (cfg_wr)
    m_wdtctl = req.din[7:0] & 8'hD3;       // HOLD NMIES TMSEL IS
  if (nmi_rise)
    m_nmiifg = 1'b1;
  else if (ifg1_wr)
    m_nmiifg = req.din[4];
  if (nacc)
    m_nmie = 1'b0;
  else if (ie1_wr)
    m_nmie = req.din[4];
  if (ie1_wr)
    m_wdtie = req.din[0];
endtask

// Read data for a request against current model state
function automatic logic [15:0] expected_read(input per_req_t req);
  logic [15:0] rd;
  logic [31:0] id;
  rd = 16'h0000;
  id = expected_cpu_id();
  if (req.en && (req.we == 2'b00)) begin
    if ((req.addr >> 3) == (`SFR_BASE_ADDR >> 3)) begin
      case (sfr_reg_e'(req.addr[2:0]))
        reg_ie1:       rd = {11'd0, m_nmie, 3'd0, m_wdtie};
        reg_ifg1:      rd = {11'd0, m_nmiifg, 3'd0, m_wdtifg};
        reg_cpu_id_lo: rd = id[15:0];
        reg_cpu_id_hi: rd = id[31:16];
        reg_cpu_nr:    rd = {cpu_nr_total, cpu_nr_inst};
        default:       rd = 16'h0000;
      endcase
    end else if (req.addr == `WDT_BASE_ADDR) begin
      rd = {`WDT_READ_KEY, m_wdtctl};
    end
  end
  return rd;
endfunction

`endif

/* tb/tb_sys_periph.sv */
`timescale 1ns/1ps

`include "sys_periph_consts.svh"

module tb_sys_periph
  import sys_periph_pkg::*;
();

  localparam int RST_CYCLES = 8;
  localparam int NUM_RANDOM = 300;
  localparam int NUM_NMI    = 20;
  localparam int NUM_BADKEY = 8;
  // Worst case length of each test in cycles
  localparam int TEST_CYCLES = RST_CYCLES + 6 + NUM_RANDOM + NUM_NMI * 18 +
                               (4 * 512 + 104) + (258 + 100 + NUM_BADKEY * 2);
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 1000;

  localparam per_req_t    BUS_IDLE    = '0;
  localparam logic [13:0] ADDR_IE1    = `SFR_BASE_ADDR + 14'(reg_ie1);
  localparam logic [13:0] ADDR_IFG1   = `SFR_BASE_ADDR + 14'(reg_ifg1);
  localparam logic [13:0] ADDR_WDTCTL = `WDT_BASE_ADDR;

  logic        mclk = 1'b0;
  logic        puc_rst;
  per_req_t    per_req;
  logic [15:0] per_dout;
  logic [7:0]  cpu_nr_inst;
  logic [7:0]  cpu_nr_total;
  logic        nmi;
  logic        nmi_acc;
  logic        wdt_irq_acc;
  logic [31:0] cpu_id;
  logic        nmi_pnd;
  logic        wdt_irq;
  logic        wdt_reset;

  logic [31:0] rng_state = 32'hc3ec_b4ad;
  logic [31:0] r;
  logic [31:0] id_exp;
  logic        pol;       // High for falling NMI edge
  logic [1:0]  we;
  logic        acc;
  per_req_t    req;
  wdt_intvl_e  is_sel;
  int          n;
  int          cycle_cnt = 0;

  `include "sys_periph_model.svh"

  sys_periph_top dut0 (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .per_req      (per_req),
    .per_dout     (per_dout),
    .cpu_nr_inst  (cpu_nr_inst),
    .cpu_nr_total (cpu_nr_total),
    .nmi          (nmi),
    .nmi_acc      (nmi_acc),
    .wdt_irq_acc  (wdt_irq_acc),
    .cpu_id       (cpu_id),
    .nmi_pnd      (nmi_pnd),
    .wdt_irq      (wdt_irq),
    .wdt_reset    (wdt_reset)
  );

  always #50 mclk = ~mclk;   // 100 ns period

  // Model sees the same inputs as the DUT at each rising edge
  always @(posedge mclk) begin
    if (puc_rst) clear_model();
    else advance_model(per_req, nmi, nmi_acc, wdt_irq_acc);
  end

  always @(posedge mclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic per_req_t bus_access(input logic [13:0] addr, input logic [15:0] din,
                                          input logic [1:0] wen);
    return '{addr: addr, din: din, en: 1'b1, we: wen};
  endfunction

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_id(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "identity mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  // Drive on the falling edge, compare all outputs once settled
  task automatic run_cycle(input string name, input per_req_t rq, input logic pin,
                           input logic nacc, input logic wacc);
    @(negedge mclk);
    per_req     = rq;
    nmi         = pin;
    nmi_acc     = nacc;
    wdt_irq_acc = wacc;
    #20;
    check_word(name, expected_read(rq), per_dout);
    check_id(name, expected_cpu_id(), cpu_id);
    check_bit({name, " nmi_pnd"}, m_nmiifg & m_nmie, nmi_pnd);
    check_bit({name, " wdt_irq"}, m_wdtifg & m_wdtie & m_wdtctl[4], wdt_irq);
    check_bit({name, " wdt_reset"}, m_wdt_reset, wdt_reset);
  endtask

  task automatic bus_cycle(input string name, input per_req_t rq);
    run_cycle(name, rq, nmi, 1'b0, 1'b0);   // Pin held
  endtask

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    puc_rst     = 1'b1;
    per_req     = BUS_IDLE;
    nmi         = 1'b0;
    nmi_acc     = 1'b0;
    wdt_irq_acc = 1'b0;
    r            = next_random();
    cpu_nr_inst  = r[7:0];
    cpu_nr_total = r[15:8];
    id_exp       = expected_cpu_id();
    clear_model();
    repeat (RST_CYCLES) @(negedge mclk);
    puc_rst = 1'b0;

    // Reset values and identity
    bus_cycle("ie1 reset", bus_access(ADDR_IE1, 16'h0000, 2'b00));
    check_word("ie1 reset", 16'h0000, per_dout);
    bus_cycle("ifg1 reset", bus_access(ADDR_IFG1, 16'h0000, 2'b00));
    check_word("ifg1 reset", 16'h0000, per_dout);
    bus_cycle("wdtctl reset", bus_access(ADDR_WDTCTL, 16'h0000, 2'b00));
    check_word("wdtctl reset", 16'h6900, per_dout);
    check_id("cpu_id port", id_exp, cpu_id);
    bus_cycle("cpu_id lo", bus_access(`SFR_BASE_ADDR + 14'(reg_cpu_id_lo), 16'h0, 2'b00));
    check_word("cpu_id lo", id_exp[15:0], per_dout);
    bus_cycle("cpu_id hi", bus_access(`SFR_BASE_ADDR + 14'(reg_cpu_id_hi), 16'h0, 2'b00));
    check_word("cpu_id hi", id_exp[31:16], per_dout);
    bus_cycle("cpu_nr", bus_access(`SFR_BASE_ADDR + 14'(reg_cpu_nr), 16'h0, 2'b00));
    check_word("cpu_nr", {cpu_nr_total, cpu_nr_inst}, per_dout);

    // Random traffic, WDTCTL kept on hold with a good key
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = next_random();
      if (r[4:2] > 3'd4)
        req = bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 1'b1, r[22:16]}, r[1:0]);
      else
        req = bus_access(`SFR_BASE_ADDR + 14'(r[4:2]), r[31:16], r[1:0]);
      bus_cycle("random access", req);
    end

    // NMI capture with random polarity and enable
    for (int i = 0; i < NUM_NMI; i++) begin
      r   = next_random();
      pol = r[0];
      run_cycle("nmi edge select", bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 1'b1, pol, 6'd0},
                2'b11), pol, 1'b0, 1'b0);
      repeat (4) bus_cycle("nmi settle", BUS_IDLE);
      bus_cycle("nmi flag clear", bus_access(ADDR_IFG1, 16'h0000, 2'b01));
      bus_cycle("nmi enable", bus_access(ADDR_IE1, {11'd0, r[1], 4'd0}, 2'b01));
      repeat (2 + r[3:2]) run_cycle("nmi pulse", BUS_IDLE, ~pol, 1'b0, 1'b0);
      repeat (4) run_cycle("nmi capture", bus_access(ADDR_IFG1, 16'h0, 2'b00), pol, 1'b0, 1'b0);
      check_bit("nmi flag set", 1'b1, per_dout[4]);
      check_bit("nmi pending", r[1], nmi_pnd);
      run_cycle("nmi accept", BUS_IDLE, pol, 1'b1, 1'b0);
      bus_cycle("nmie after accept", bus_access(ADDR_IE1, 16'h0000, 2'b00));
      check_bit("nmie after accept", 1'b0, per_dout[4]);
    end

    // Interval timer with accepts and software strobes
    r      = next_random();
    is_sel = r[0] ? intvl_64 : intvl_512;
    bus_cycle("wdt irq enable", bus_access(ADDR_IE1, 16'h0001, 2'b01));
    bus_cycle("wdt flag clear", bus_access(ADDR_IFG1, 16'h0000, 2'b01));
    bus_cycle("interval start", bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 6'b000110, is_sel},
              2'b11));   // TMSEL and CNTCL
    for (int i = 0; i < 4 * interval_len(is_sel) + 100; i++) begin
      r = next_random();
      if (r[5:0] == 6'd0)
        req = bus_access(ADDR_IFG1, {15'd0, r[6]}, 2'b01);    // Set or clear strobe
      else if (r[3:0] == 4'd1)
        req = bus_access(ADDR_IFG1, 16'h0000, 2'b00);
      else
        req = BUS_IDLE;
      acc = m_wdtifg & m_wdtie & m_wdtctl[4] & (r[9:8] == 2'd0);
      run_cycle("interval", req, nmi, 1'b0, acc);
      check_bit("interval no reset", 1'b0, wdt_reset);
    end
    bus_cycle("interval stop", bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 8'h80}, 2'b11));

    // Watchdog mode at 64, kicked then left to expire
    bus_cycle("wdog start", bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 8'h0B}, 2'b11));
    for (int i = 0; i < 240; i++) begin
      if (i % 40 == 39) req = bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 8'h0B}, 2'b11);
      else req = BUS_IDLE;
      bus_cycle("wdog kick", req);
      check_bit("wdog kick no reset", 1'b0, wdt_reset);
    end
    n = 0;
    while (wdt_reset !== 1'b1 && n < 100) begin
      bus_cycle("wdog expiry", BUS_IDLE);
      n++;
    end
    if (wdt_reset !== 1'b1) begin
      $display("Watchdog reset did not pulse after the counter ran out");
      $display("Simulation failed");
      $fatal(1, "no watchdog reset");
    end
    bus_cycle("wdog hold", bus_access(ADDR_WDTCTL, {`WDT_PASSWORD, 8'h80}, 2'b11));

    // Wrong key pulses reset and leaves WDTCTL alone
    for (int i = 0; i < NUM_BADKEY; i++) begin
      r = next_random();
      if (r[15:8] == `WDT_PASSWORD) r[15:8] = ~r[15:8];
      we = (r[17:16] == 2'b00) ? 2'b11 : r[17:16];
      bus_cycle("bad key write", bus_access(ADDR_WDTCTL, r[15:0], we));
      bus_cycle("bad key read", bus_access(ADDR_WDTCTL, 16'h0000, 2'b00));
      check_bit("bad key reset", 1'b1, wdt_reset);
      check_word("bad key wdtctl", {`WDT_READ_KEY, 8'h80}, per_dout);
    end

    bus_cycle("final", BUS_IDLE);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
+incdir+tb
common/sys_periph_pkg.sv
sfr/sfr_regs.sv
watchdog/watchdog_timer.sv
verilog/sys_periph_top.sv
tb/tb_sys_periph.sv

/* Bender.yml */
package:
  name: sys_periph

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sys_periph_pkg.sv
      - sfr/sfr_regs.sv
      - watchdog/watchdog_timer.sv
      - verilog/sys_periph_top.sv
  - target: test
    include_dirs:
      - common
      - tb
    files:
      - tb/tb_sys_periph.sv
